/* icache_defs.svh */
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// fetch address width
`define ICACHE_ADDR_W 32

// cache geometry
`define ICACHE_WAYS 4
`define ICACHE_SETS 16
`define ICACHE_INDEX_W 4

// 64-byte lines
`define ICACHE_OFFSET_W 6
`define ICACHE_WORDS 16

// refill burst, four beats of 128 bits
`define ICACHE_BEAT_W 128
`define ICACHE_BEATS 4

// address bits above index and offset
`define ICACHE_TAG_W 22

// cacheable window, both ends inclusive
`define ICACHE_MEM_LO 32'h8000_0000
`define ICACHE_MEM_HI 32'h9FFF_FFFF

`endif

/* icache_pkg.sv */
`default_nettype none

`include "icache_defs.svh"

package icache_pkg;

    typedef enum logic [2:0] {
        RUN,
        MISS_REQ,
        MISS_WAIT,
        BEAT_1,
        BEAT_2,
        BEAT_3,
        FILL_DONE
    } ctrl_state_e;

    typedef enum logic [4:0] {
        MISALIGNED   = 5'd0,
        ACCESS_FAULT = 5'd1
    } exc_code_e;

    // read command to every way
    typedef struct packed {
        logic                          en;
        logic [`ICACHE_INDEX_W-1:0]    index;
        logic [`ICACHE_OFFSET_W-3:0]   word;
    } lookup_t;

    // beat write and tag write to the selected way
    typedef struct packed {
        logic                             data_we;
        logic [$clog2(`ICACHE_BEATS)-1:0] beat;
        logic [`ICACHE_INDEX_W-1:0]       index;
        logic [`ICACHE_BEAT_W-1:0]        data;
        logic                             tag_we;
        logic                             tag_valid;
        logic [`ICACHE_TAG_W-1:0]         tag;
    } fill_t;

    typedef struct packed {
        logic                       valid;
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic [31:0]                word;
    } way_probe_t;

    typedef struct packed {
        logic                       lookup_valid;
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic                       exc_valid;
        exc_code_e                  exc_code;
        logic                       refill_valid;
        logic [31:0]                refill_word;
        logic [1:0]                 fill_way;
    } stage_t;

    typedef struct packed {
        logic                       valid;
        logic [`ICACHE_ADDR_W-1:0]  addr;
    } ar_t;

    typedef struct packed {
        logic                       valid;
        logic [`ICACHE_BEAT_W-1:0]  data;
        logic                       err;
    } r_beat_t;

endpackage

`default_nettype wire

/* icache_way.sv */
`default_nettype none

`include "icache_defs.svh"

module icache_way (
    input  wire logic                   clk,
    input  wire logic                   resetn,
    input  wire icache_pkg::lookup_t    lookup_i,
    input  wire icache_pkg::fill_t      fill_i,
    input  wire logic                   fill_sel_i,
    output icache_pkg::way_probe_t      probe_o
);

    logic [`ICACHE_SETS-1:0]    valid_q;
    logic [`ICACHE_TAG_W-1:0]   tag_mem [`ICACHE_SETS];
    logic [31:0]                data_mem [`ICACHE_SETS*`ICACHE_WORDS];

    logic                       probe_valid_q;
    logic [`ICACHE_TAG_W-1:0]   probe_tag_q;
    logic [31:0]                probe_word_q;

    logic                       tag_wr;
    logic                       data_wr;

    assign tag_wr  = fill_sel_i && fill_i.tag_we;
    assign data_wr = fill_sel_i && fill_i.data_we;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            valid_q       <= '0;
            probe_valid_q <= 1'b0;
        end else begin
            if (tag_wr) begin
                valid_q[fill_i.index] <= fill_i.tag_valid;
            end
            if (lookup_i.en) begin
                probe_valid_q <= valid_q[lookup_i.index];
            end
        end
    end

    // storage arrays and probe payload
    always_ff @(posedge clk) begin
        if (tag_wr) begin
            tag_mem[fill_i.index] <= fill_i.tag;
        end
        if (data_wr) begin
            // one beat covers four consecutive words
            for (int i = 0; i < `ICACHE_BEAT_W / 32; i++) begin
                data_mem[{fill_i.index, fill_i.beat, 2'(i)}] <= fill_i.data[32*i +: 32];
            end
        end
        if (lookup_i.en) begin
            probe_tag_q  <= tag_mem[lookup_i.index];
            probe_word_q <= data_mem[{lookup_i.index, lookup_i.word}];
        end
    end

    always_comb begin
        probe_o.valid = probe_valid_q;
        probe_o.tag   = probe_tag_q;
        probe_o.word  = probe_word_q;
    end

endmodule

`default_nettype wire

/* icache_ctrl.sv */
`default_nettype none

`include "icache_defs.svh"

module icache_ctrl (
    input  wire logic                       clk,
    input  wire logic                       resetn,
    input  wire logic                       instr_mem_req_i,
    input  wire logic [`ICACHE_ADDR_W-1:0]  instr_mem_addr_i,
    output logic                            instr_mem_ready_o,
    input  wire logic                       instr_ready_i,
    input  wire logic                       kill_i,
    output icache_pkg::ar_t                 ar_o,
    input  wire logic                       arready_i,
    input  wire icache_pkg::r_beat_t        r_i,
    output logic                            rready_o,
    input  wire logic                       hit_i,
    input  wire logic [1:0]                 victim_i,
    output icache_pkg::lookup_t             lookup_o,
    output icache_pkg::fill_t               fill_o,
    output logic [`ICACHE_WAYS-1:0]         fill_sel_o,
    output icache_pkg::stage_t              stage_o
);

    icache_pkg::ctrl_state_e            state_q;
    logic                               req_q;
    logic [`ICACHE_ADDR_W-1:0]          addr_q;
    logic [1:0]                         fill_way_q;
    logic                               kill_q;
    logic                               err_q;
    logic [31:0]                        hold_q;

    logic                               in_run;
    logic                               in_done;
    logic                               in_refill;
    logic                               misaligned;
    logic                               out_of_window;
    logic                               exc_run;
    logic                               miss;
    logic                               out_valid;
    logic                               accept;
    logic                               beat_take;
    logic [$clog2(`ICACHE_BEATS)-1:0]   beat_idx;
    logic [`ICACHE_OFFSET_W-3:0]        req_word;

    assign in_run    = state_q == icache_pkg::RUN;
    assign in_done   = state_q == icache_pkg::FILL_DONE;
    assign in_refill = state_q inside {icache_pkg::MISS_REQ, icache_pkg::MISS_WAIT,
                                       icache_pkg::BEAT_1, icache_pkg::BEAT_2,
                                       icache_pkg::BEAT_3};
    assign rready_o  = in_refill && state_q != icache_pkg::MISS_REQ;
    assign beat_take = rready_o && r_i.valid;
    assign req_word  = addr_q[`ICACHE_OFFSET_W-1:2];

    // exception check on the registered address
    assign misaligned    = addr_q[1:0] != 2'b00;
    assign out_of_window = addr_q < `ICACHE_MEM_LO || addr_q > `ICACHE_MEM_HI;
    assign exc_run       = in_run && req_q && (misaligned || out_of_window);
    assign miss          = in_run && req_q && !exc_run && !hit_i;
    assign out_valid     = exc_run || hit_i;

    assign instr_mem_ready_o = in_run && !miss && !(out_valid && !instr_ready_i);
    assign accept            = instr_mem_req_i && instr_mem_ready_o;

    always_comb begin
        case (state_q)
            icache_pkg::BEAT_1: beat_idx = 2'd1;
            icache_pkg::BEAT_2: beat_idx = 2'd2;
            icache_pkg::BEAT_3: beat_idx = 2'd3;
            default:            beat_idx = 2'd0;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state_q <= icache_pkg::RUN;
            req_q   <= 1'b0;
            kill_q  <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                icache_pkg::RUN: begin
                    if (accept) begin
                        req_q <= 1'b1;
                    end else if (miss) begin
                        // stale lookup is dropped once the refill starts
                        req_q   <= 1'b0;
                        kill_q  <= 1'b0;
                        err_q   <= 1'b0;
                        state_q <= icache_pkg::MISS_REQ;
                    end else if (out_valid && instr_ready_i) begin
                        req_q <= 1'b0;
                    end
                end
                icache_pkg::MISS_REQ: begin
                    if (arready_i) state_q <= icache_pkg::MISS_WAIT;
                end
                icache_pkg::MISS_WAIT: begin
                    if (r_i.valid) state_q <= icache_pkg::BEAT_1;
                end
                icache_pkg::BEAT_1: begin
                    if (r_i.valid) state_q <= icache_pkg::BEAT_2;
                end
                icache_pkg::BEAT_2: begin
                    if (r_i.valid) state_q <= icache_pkg::BEAT_3;
                end
                icache_pkg::BEAT_3: begin
                    if (r_i.valid) state_q <= icache_pkg::FILL_DONE;
                end
                icache_pkg::FILL_DONE: begin
                    if (kill_q || instr_ready_i) state_q <= icache_pkg::RUN;
                end
                default: state_q <= icache_pkg::RUN;
            endcase

            if (in_refill) kill_q <= kill_q | kill_i;
            if (beat_take) err_q <= err_q | r_i.err;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) addr_q <= instr_mem_addr_i;
        if (miss) fill_way_q <= victim_i;
        // keep the requested word as its beat goes by
        if (beat_take && beat_idx == req_word[3:2]) begin
            hold_q <= r_i.data[32*req_word[1:0] +: 32];
        end
    end

    always_comb begin
        lookup_o.en    = accept;
        lookup_o.index = instr_mem_addr_i[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        lookup_o.word  = instr_mem_addr_i[`ICACHE_OFFSET_W-1:2];

        ar_o.valid = state_q == icache_pkg::MISS_REQ;
        ar_o.addr  = {addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
    end

    always_comb begin
        fill_o.data_we   = beat_take;
        fill_o.beat      = beat_idx;
        fill_o.index     = addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        fill_o.data      = r_i.data;
        // line only becomes valid after a clean, unkilled burst
        fill_o.tag_we    = in_done;
        fill_o.tag_valid = !kill_q && !err_q;
        fill_o.tag       = addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    end

    assign fill_sel_o = `ICACHE_WAYS'(1) << fill_way_q;

    always_comb begin
        stage_o.lookup_valid = in_run && req_q && !exc_run;
        stage_o.tag          = addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        stage_o.exc_valid    = exc_run || (in_done && err_q && !kill_q);
        if (in_done || out_of_window) begin
            stage_o.exc_code = icache_pkg::ACCESS_FAULT;
        end else begin
            stage_o.exc_code = icache_pkg::MISALIGNED;
        end
        stage_o.refill_valid = in_done && !kill_q && !err_q;
        stage_o.refill_word  = hold_q;
        stage_o.fill_way     = fill_way_q;
    end

endmodule

`default_nettype wire

/* icache_hit_select.sv */
`default_nettype none

`include "icache_defs.svh"

module icache_hit_select (
    input  wire logic                                       clk,
    input  wire logic                                       resetn,
    input  wire icache_pkg::way_probe_t [`ICACHE_WAYS-1:0]  probe_i,
    input  wire icache_pkg::stage_t                         stage_i,
    input  wire logic                                       instr_ready_i,
    output logic [31:0]                                     instr_o,
    output logic                                            instr_valid_o,
    output logic                                            exc_valid_o,
    output icache_pkg::exc_code_e                           exc_code_o,
    output logic                                            hit_o,
    output logic [1:0]                                      victim_o
);

    logic [`ICACHE_WAYS-1:0]    hit_vec;
    logic [1:0]                 hit_way;
    logic [1:0]                 acc_way;
    logic [1:0]                 tree_way;
    logic [2:0]                 plru_q;
    logic [2:0]                 plru_d;
    logic                       plru_upd;

    always_comb begin
        hit_vec = '0;
        hit_way = 2'd0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit_vec[w] = probe_i[w].valid && probe_i[w].tag == stage_i.tag;
            if (hit_vec[w]) hit_way = 2'(w);
        end
    end

    assign hit_o         = stage_i.lookup_valid && |hit_vec;
    assign instr_valid_o = hit_o || stage_i.refill_valid;
    assign instr_o       = stage_i.refill_valid ? stage_i.refill_word : probe_i[hit_way].word;
    assign exc_valid_o   = stage_i.exc_valid;
    assign exc_code_o    = stage_i.exc_code;

    // tree bits {b2, b1, b0}
    assign acc_way  = stage_i.refill_valid ? stage_i.fill_way : hit_way;
    assign plru_upd = instr_valid_o && instr_ready_i;

    always_comb begin
        case (acc_way)
            2'd0:    plru_d = {2'b11, plru_q[0]};
            2'd1:    plru_d = {2'b10, plru_q[0]};
            2'd2:    plru_d = {1'b0, plru_q[1], 1'b1};
            default: plru_d = {1'b0, plru_q[1], 1'b0};
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            plru_q <= 3'b000;
        end else if (plru_upd) begin
            plru_q <= plru_d;
        end
    end

    assign tree_way = plru_q[2] ? (plru_q[0] ? 2'd3 : 2'd2) : (plru_q[1] ? 2'd1 : 2'd0);

    // lowest invalid way wins over the tree
    always_comb begin
        victim_o = tree_way;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!probe_i[w].valid) victim_o = 2'(w);
        end
    end

endmodule

`default_nettype wire

/* icache_top.sv */
`default_nettype none

`include "icache_defs.svh"

module icache_top (
    input  wire logic                       clk,
    input  wire logic                       resetn,
    input  wire logic                       instr_mem_req_i,
    input  wire logic [`ICACHE_ADDR_W-1:0]  instr_mem_addr_i,
    output logic                            instr_mem_ready_o,
    input  wire logic                       instr_ready_i,
    output logic [31:0]                     instr_o,
    output logic                            instr_valid_o,
    input  wire logic                       kill_i,
    output logic                            exc_valid_o,
    output icache_pkg::exc_code_e           exc_code_o,
    output icache_pkg::ar_t                 ar_o,
    input  wire logic                       arready_i,
    input  wire icache_pkg::r_beat_t        r_i,
    output logic                            rready_o
);

    icache_pkg::lookup_t                        lookup;
    icache_pkg::fill_t                          fill;
    icache_pkg::stage_t                         stage;
    icache_pkg::way_probe_t [`ICACHE_WAYS-1:0]  probes;
    logic [`ICACHE_WAYS-1:0]                    fill_sel;
    logic                                       hit;
    logic [1:0]                                 victim;

    icache_ctrl u_ctrl (
        .clk               (clk),
        .resetn            (resetn),
        .instr_mem_req_i   (instr_mem_req_i),
        .instr_mem_addr_i  (instr_mem_addr_i),
        .instr_mem_ready_o (instr_mem_ready_o),
        .instr_ready_i     (instr_ready_i),
        .kill_i            (kill_i),
        .ar_o              (ar_o),
        .arready_i         (arready_i),
        .r_i               (r_i),
        .rready_o          (rready_o),
        .hit_i             (hit),
        .victim_i          (victim),
        .lookup_o          (lookup),
        .fill_o            (fill),
        .fill_sel_o        (fill_sel),
        .stage_o           (stage)
    );

    for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : g_way
        icache_way u_way (
            .clk        (clk),
            .resetn     (resetn),
            .lookup_i   (lookup),
            .fill_i     (fill),
            .fill_sel_i (fill_sel[g]),
            .probe_o    (probes[g])
        );
    end

    icache_hit_select u_hit_select (
        .clk           (clk),
        .resetn        (resetn),
        .probe_i       (probes),
        .stage_i       (stage),
        .instr_ready_i (instr_ready_i),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o),
        .exc_valid_o   (exc_valid_o),
        .exc_code_o    (exc_code_o),
        .hit_o         (hit),
        .victim_o      (victim)
    );

endmodule

`default_nettype wire

/* tb_axi_mem.sv */
`default_nettype none

`include "icache_defs.svh"

module tb_axi_mem (
    input  wire logic               clk,
    input  wire logic               resetn,
    input  wire icache_pkg::ar_t    ar_i,
    output logic                    arready_o,
    output icache_pkg::r_beat_t     r_o,
    input  wire logic               rready_i,
    input  wire logic               err_en_i
);

    logic [31:0]    rnd;
    logic           busy;
    logic [31:0]    line_addr;
    logic           ar_take;
    logic           r_take;
    int             beat;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // four words of one beat, each derived from its own byte address
    function automatic logic [`ICACHE_BEAT_W-1:0] beat_data(input logic [31:0] addr);
        logic [`ICACHE_BEAT_W-1:0] d;
        for (int i = 0; i < `ICACHE_BEAT_W / 32; i++) begin
            d[32*i +: 32] = (addr + 32'(4 * i)) ^ 32'hC0DE_0000;
        end
        return d;
    endfunction

    initial begin
        rnd       = 32'h2d74;
        busy      = 1'b0;
        line_addr = '0;
        beat      = 0;
        arready_o = 1'b0;
        r_o       = '0;
        forever begin
            // handshakes are stable from mid-cycle up to the next edge
            @(negedge clk);
            ar_take = ar_i.valid && arready_o;
            r_take  = r_o.valid && rready_i;
            @(posedge clk);
            #1;
            if (!resetn) begin
                busy = 1'b0;
            end else if (!busy && ar_take) begin
                busy      = 1'b1;
                line_addr = ar_i.addr;
                beat      = 0;
            end else if (busy && r_take) begin
                beat++;
                if (beat == `ICACHE_BEATS) begin
                    busy = 1'b0;
                end
            end
            // random gaps on both channels
            rnd       = xorshift(rnd);
            arready_o = resetn && !busy && rnd[1:0] != 2'b00;
            r_o.valid = busy && rnd[3:2] != 2'b00;
            r_o.data  = beat_data(line_addr + 32'(16 * beat));
            r_o.err   = busy && err_en_i && beat == 2;
        end
    end

endmodule

`default_nettype wire

/* tb_icache.sv */
`default_nettype none

`include "icache_defs.svh"

module tb_icache;

    localparam int CLK_PERIOD = 4;
    // fetches issued by the sequence below
    localparam int FETCHES = 20;

    typedef enum logic [1:0] {
        EXP_INSTR,
        EXP_EXC,
        EXP_KILL
    } outcome_e;

    logic                       clk;
    logic                       resetn;
    logic                       mem_req;
    logic [`ICACHE_ADDR_W-1:0]  mem_addr;
    logic                       mem_ready;
    logic                       instr_ready;
    logic [31:0]                instr;
    logic                       instr_valid;
    logic                       kill;
    logic                       exc_valid;
    icache_pkg::exc_code_e      exc_code;
    icache_pkg::ar_t            ar;
    logic                       arready;
    icache_pkg::r_beat_t        r_beat;
    logic                       rready;
    logic                       err_en;

    // expectation of the fetch in flight
    logic [31:0]                fetch_addr;
    outcome_e                   exp_kind;
    icache_pkg::exc_code_e      exp_code;
    logic                       exp_miss;
    int                         ar_base;
    int                         ar_total;

    icache_top dut0 (
        .clk               (clk),
        .resetn            (resetn),
        .instr_mem_req_i   (mem_req),
        .instr_mem_addr_i  (mem_addr),
        .instr_mem_ready_o (mem_ready),
        .instr_ready_i     (instr_ready),
        .instr_o           (instr),
        .instr_valid_o     (instr_valid),
        .kill_i            (kill),
        .exc_valid_o       (exc_valid),
        .exc_code_o        (exc_code),
        .ar_o              (ar),
        .arready_i         (arready),
        .r_i               (r_beat),
        .rready_o          (rready)
    );

    tb_axi_mem mem0 (
        .clk       (clk),
        .resetn    (resetn),
        .ar_i      (ar),
        .arready_o (arready),
        .r_o       (r_beat),
        .rready_i  (rready),
        .err_en_i  (err_en)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ar_total <= 0;
        end else if (ar.valid && arready) begin
            ar_total <= ar_total + 1;
        end
    end

    task automatic fail_value(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    a_reset_idle: assert property (@(posedge clk)
        !resetn |-> !instr_valid && !exc_valid && !ar.valid && !rready && mem_ready)
        else fail_value("outputs not idle during reset");
    a_req_addr: assert property (@(posedge clk) disable iff (!resetn)
        ar.valid |-> ar.addr == (fetch_addr & ~32'h3F))
        else fail_value("request address is not the line address");
    a_req_once: assert property (@(posedge clk) disable iff (!resetn)
        ar.valid |-> exp_miss && ar_total == ar_base)
        else fail_value("unexpected read request");
    a_rready_idle: assert property (@(posedge clk) disable iff (!resetn)
        (mem_ready || ar.valid) |-> !rready)
        else fail_value("read data accepted outside a refill");
    a_req_count: assert property (@(posedge clk) disable iff (!resetn)
        (instr_valid || exc_valid) |-> ar_total - ar_base == (exp_miss ? 1 : 0))
        else fail_value("wrong number of read requests for this fetch");
    a_instr_word: assert property (@(posedge clk) disable iff (!resetn)
        instr_valid |-> exp_kind == EXP_INSTR && instr == (fetch_addr ^ 32'hC0DE_0000))
        else fail_value("wrong or unexpected instruction");
    a_exc_code: assert property (@(posedge clk) disable iff (!resetn)
        exc_valid |-> exp_kind == EXP_EXC && exc_code == exp_code)
        else fail_value("wrong or unexpected exception");
    a_one_result: assert property (@(posedge clk) disable iff (!resetn)
        !(instr_valid && exc_valid))
        else fail_value("instruction and exception at once");
    a_hold_instr: assert property (@(posedge clk) disable iff (!resetn)
        instr_valid && !instr_ready |=> instr_valid && $stable(instr))
        else fail_value("instruction not held under back-pressure");
    a_hold_exc: assert property (@(posedge clk) disable iff (!resetn)
        exc_valid && !instr_ready |=> exc_valid && $stable(exc_code))
        else fail_value("exception not held under back-pressure");
    a_no_accept: assert property (@(posedge clk) disable iff (!resetn)
        (instr_valid || exc_valid) && !instr_ready |-> !mem_ready)
        else fail_value("new fetch accepted under back-pressure");

    initial begin
        #(200 * FETCHES * CLK_PERIOD + 10 * CLK_PERIOD);
        $display("timeout: the fetch sequence did not finish in time");
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // k-th line of the set shared by the replacement test
    function automatic logic [31:0] shared_set_addr(input int k);
        return 32'h8010_0140 + 32'(k) * 32'h400 + 32'(4 * k);
    endfunction

    task automatic fetch(input logic [31:0] addr, input outcome_e kind,
                         input icache_pkg::exc_code_e code, input logic miss,
                         input int hold);
        while (!mem_ready) next_cycle();
        fetch_addr = addr;
        exp_kind   = kind;
        exp_code   = code;
        exp_miss   = miss;
        ar_base    = ar_total;
        mem_req    = 1'b1;
        mem_addr   = addr;
        next_cycle();
        mem_req = 1'b0;
        if (kind == EXP_KILL) begin
            while (ar_total == ar_base) next_cycle();
            kill = 1'b1;
            next_cycle();
            kill = 1'b0;
            while (!mem_ready) next_cycle();
        end else begin
            while (!instr_valid && !exc_valid) next_cycle();
            repeat (hold) next_cycle();
            instr_ready = 1'b1;
            next_cycle();
            instr_ready = 1'b0;
        end
    endtask

    initial begin
        resetn      = 1'b1;
        mem_req     = 1'b0;
        mem_addr    = '0;
        instr_ready = 1'b0;
        kill        = 1'b0;
        err_en      = 1'b0;
        fetch_addr  = '0;
        exp_kind    = EXP_INSTR;
        exp_code    = icache_pkg::MISALIGNED;
        exp_miss    = 1'b0;
        ar_base     = 0;
        #1;
        resetn = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        resetn = 1'b1;

        // cold miss, then a held hit in the same line
        fetch(32'h8000_0024, EXP_INSTR, icache_pkg::ACCESS_FAULT, 1'b1, 0);
        fetch(32'h8000_0038, EXP_INSTR, icache_pkg::ACCESS_FAULT, 1'b0, 3);

        // fill ways 0..3, then hits on ways 0 and 3 leave way 1 as victim
        for (int k = 0; k < 4; k++) begin
            fetch(shared_set_addr(k), EXP_INSTR, icache_pkg::ACCESS_FAULT, 1'b1, 0);
        end
        fetch(shared_set_addr(0), EXP_INSTR, icache_pkg::ACCESS_FAULT, 1'b0, 0);
        fetch(shared_set_addr(3), EXP_INSTR, icache_pkg::ACCESS_FAULT, 1'b0, 0);
        fetch(shared_set_addr(4), EXP_INSTR, icache_pkg::ACCESS_FAULT, 1'b1, 0);
        fetch(shared_set_addr(0), EXP_INSTR, icache_pkg::ACCESS_FAULT, 1'b0, 0);
        fetch(shared_set_addr(2), EXP_INSTR, icache_pkg::ACCESS_FAULT, 1'b0, 0);
        fetch(shared_set_addr(3), EXP_INSTR, icache_pkg::ACCESS_FAULT, 1'b0, 0);
        fetch(shared_set_addr(4), EXP_INSTR, icache_pkg::ACCESS_FAULT, 1'b0, 0);
        fetch(shared_set_addr(1), EXP_INSTR, icache_pkg::ACCESS_FAULT, 1'b1, 0);

        // address exceptions
        fetch(32'h8000_1002, EXP_EXC, icache_pkg::MISALIGNED, 1'b0, 1);
        fetch(32'h4000_0100, EXP_EXC, icache_pkg::ACCESS_FAULT, 1'b0, 0);

        // bus error on the refill, then a clean refetch
        err_en = 1'b1;
        fetch(32'h8000_0c44, EXP_EXC, icache_pkg::ACCESS_FAULT, 1'b1, 2);
        err_en = 1'b0;
        fetch(32'h8000_0c44, EXP_INSTR, icache_pkg::ACCESS_FAULT, 1'b1, 0);

        // killed refill leaves the line uncached
        fetch(32'h8000_0884, EXP_KILL, icache_pkg::ACCESS_FAULT, 1'b1, 0);
        fetch(32'h8000_0884, EXP_INSTR, icache_pkg::ACCESS_FAULT, 1'b1, 0);

        repeat (4) next_cycle();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
icache_pkg.sv
icache_way.sv
icache_ctrl.sv
icache_hit_select.sv
icache_top.sv
tb_axi_mem.sv
tb_icache.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f flist.f \
        --top-module tb_icache -o tb_icache \
    && ./obj_dir/tb_icache \
    || { echo "simulation failed"; exit 1; }
